// ==== Bender.yml ====
package:
  name: instr_decode_stage

sources:
  # Design sources in compile order
  - files:
      - src/decode_pkg.sv
      - src/base_int_decoder.sv
      - src/bitmanip_decoder.sv
      - src/system_decoder.sv
      - src/decode_ctrl.sv
      - src/instr_decode_stage.sv

  # Testbench, top module tb_instr_decode_stage
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_instr_decode_stage.sv

// ==== flist.f ====
src/decode_pkg.sv
src/base_int_decoder.sv
src/bitmanip_decoder.sv
src/system_decoder.sv
src/decode_ctrl.sv
src/instr_decode_stage.sv
verif/tb_clk_gen.sv
verif/tb_instr_decode_stage.sv

// ==== src/base_int_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module base_int_decoder import decode_pkg::*; #(
   parameter bit SUPPORT_M = 1'b1
) (
   input  instr_u      instr_i,
   output dec_result_t res_o
);

   logic [6:0] funct7;
   logic [2:0] funct3;
   logic       alt;

   assign funct7 = instr_i.r_view.funct7;
   assign funct3 = instr_i.r_view.funct3;
   assign alt    = (funct7 == F7_ALT);

   function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic use_alt);
      case (f3)
         F3_ADD:  alu_from_funct3 = use_alt ? ALU_SUB : ALU_ADD;
         F3_SLL:  alu_from_funct3 = ALU_SLL;
         F3_SLT:  alu_from_funct3 = ALU_SLT;
         F3_SLTU: alu_from_funct3 = ALU_SLTU;
         F3_XOR:  alu_from_funct3 = ALU_XOR;
         F3_SRL:  alu_from_funct3 = use_alt ? ALU_SRA : ALU_SRL;
         F3_OR:   alu_from_funct3 = ALU_OR;
         default: alu_from_funct3 = ALU_AND;
      endcase
   endfunction

   always_comb begin
      res_o = '0;
      case (instr_i.r_view.opcode)
         OPC_LOAD: begin
            res_o.hit            = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
            res_o.ctrl.exc_cause = EXC_LOAD_MISALIGN;
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.wb_sel    = WB_MEM;
            res_o.ctrl.op2_imm   = 1'b1;
            res_o.ctrl.is_load   = 1'b1;
         end
         OPC_STORE: begin
            res_o.hit            = funct3 inside {F3_SB, F3_SH, F3_SW};
            res_o.ctrl.exc_cause = EXC_STORE_MISALIGN;
            res_o.ctrl.op2_imm   = 1'b1;
            res_o.ctrl.is_store  = 1'b1;
         end
         OPC_BRANCH: begin
            res_o.hit = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
            // Target computed as pc + imm
            res_o.ctrl.exc_cause = EXC_INSTR_MISALIGN;
            res_o.ctrl.op1_pc    = 1'b1;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_JAL: begin
            res_o.hit            = 1'b1;
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.wb_sel    = WB_PC4;
            res_o.ctrl.op1_pc    = 1'b1;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_JALR: begin
            res_o.hit            = (funct3 == F3_JALR);
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.wb_sel    = WB_PC4;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_LUI: begin
            res_o.hit            = 1'b1;
            res_o.ctrl.alu_op    = ALU_PASS_B;
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_AUIPC: begin
            res_o.hit            = 1'b1;
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.op1_pc    = 1'b1;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_OP_IMM: begin
            // Shift immediates leave other funct7 values to the B group
            case (funct3)
               F3_SLL:  res_o.hit = (funct7 == F7_BASE);
               F3_SRL:  res_o.hit = (funct7 == F7_BASE) || alt;
               default: res_o.hit = 1'b1;
            endcase
            res_o.ctrl.alu_op    = alu_from_funct3(funct3, alt && (funct3 == F3_SRL));
            res_o.ctrl.reg_wr_en = 1'b1;
            res_o.ctrl.op2_imm   = 1'b1;
         end
         OPC_OP: begin
            res_o.ctrl.reg_wr_en = 1'b1;
            if (funct7 == F7_MULDIV) begin
               res_o.hit         = SUPPORT_M;
               res_o.ctrl.unit   = UNIT_MDU;
               res_o.ctrl.mdu_en = 1'b1;
               res_o.ctrl.mdu_op = funct3;
            end else begin
               res_o.hit = (funct7 == F7_BASE) || (alt && funct3 inside {F3_ADD, F3_SRL});
               res_o.ctrl.alu_op     = alu_from_funct3(funct3, alt);
               res_o.ctrl.rs2_negate = alt && (funct3 == F3_ADD);
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/bitmanip_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_decoder import decode_pkg::*; #(
   parameter bit SUPPORT_B = 1'b1
) (
   input  instr_u      instr_i,
   output dec_result_t res_o
);

   logic [9:0] f7_f3;
   logic [4:0] funct5;
   logic       match;
   logic       rori;

   assign f7_f3  = {instr_i.r_view.funct7, instr_i.r_view.funct3};
   assign funct5 = instr_i.r_view.rs2;

   always_comb begin
      res_o = '0;
      match = 1'b0;
      rori  = 1'b0;
      res_o.ctrl.unit      = UNIT_BMU;
      res_o.ctrl.reg_wr_en = 1'b1;
      res_o.ctrl.op2_imm   = (instr_i.r_view.opcode == OPC_OP_IMM);

      if (instr_i.r_view.opcode == OPC_OP_IMM) begin
         case (f7_f3)
            {F7_ROTATE, F3_SLL}: begin
               // Unary ops, selected by funct5
               match = 1'b1;
               case (funct5)
                  F5_CLZ:    res_o.ctrl.bmu_op = BMU_CLZ;
                  F5_CTZ:    res_o.ctrl.bmu_op = BMU_CTZ;
                  F5_CPOP:   res_o.ctrl.bmu_op = BMU_CPOP;
                  F5_SEXT_B: res_o.ctrl.bmu_op = BMU_SEXT_B;
                  F5_SEXT_H: res_o.ctrl.bmu_op = BMU_SEXT_H;
                  default:   match = 1'b0;
               endcase
            end
            {F7_ROTATE, F3_SRL}: begin
               match = 1'b1;
               rori  = 1'b1;
               res_o.ctrl.bmu_op = BMU_ROR;
            end
            {F7_BCLR_BEXT, F3_SLL}: begin
               match = 1'b1;
               res_o.ctrl.bmu_op = BMU_BCLR;
            end
            {F7_BCLR_BEXT, F3_SRL}: begin
               match = 1'b1;
               res_o.ctrl.bmu_op = BMU_BEXT;
            end
            {F7_BINV_REV8, F3_SLL}: begin
               match = 1'b1;
               res_o.ctrl.bmu_op = BMU_BINV;
            end
            {F7_BINV_REV8, F3_SRL}: begin
               match = (funct5 == F5_REV8);
               res_o.ctrl.bmu_op = BMU_REV8;
            end
            {F7_BSET_ORCB, F3_SLL}: begin
               match = 1'b1;
               res_o.ctrl.bmu_op = BMU_BSET;
            end
            {F7_BSET_ORCB, F3_SRL}: begin
               match = (funct5 == F5_ORC_B);
               res_o.ctrl.bmu_op = BMU_ORC_B;
            end
            default: ;
         endcase
      end else if (instr_i.r_view.opcode == OPC_OP) begin
         match = 1'b1;
         case (f7_f3)
            {F7_ROTATE, F3_SLL}:    res_o.ctrl.bmu_op = BMU_ROL;
            {F7_ROTATE, F3_SRL}:    res_o.ctrl.bmu_op = BMU_ROR;
            {F7_BCLR_BEXT, F3_SLL}: res_o.ctrl.bmu_op = BMU_BCLR;
            {F7_BCLR_BEXT, F3_SRL}: res_o.ctrl.bmu_op = BMU_BEXT;
            {F7_BINV_REV8, F3_SLL}: res_o.ctrl.bmu_op = BMU_BINV;
            {F7_BSET_ORCB, F3_SLL}: res_o.ctrl.bmu_op = BMU_BSET;
            {F7_MINMAX, F3_MIN}:    res_o.ctrl.bmu_op = BMU_MIN;
            {F7_MINMAX, F3_MINU}:   res_o.ctrl.bmu_op = BMU_MINU;
            {F7_MINMAX, F3_MAX}:    res_o.ctrl.bmu_op = BMU_MAX;
            {F7_MINMAX, F3_MAXU}:   res_o.ctrl.bmu_op = BMU_MAXU;
            {F7_ZEXT_H, F3_ZEXT_H}: begin
               match = (funct5 == F5_ZEXT_H);
               res_o.ctrl.bmu_op = BMU_ZEXT_H;
            end
            // Logic with inverted operand runs on the ALU
            {F7_ALT, F3_AND}: begin
               res_o.ctrl.unit       = UNIT_ALU;
               res_o.ctrl.alu_op     = ALU_AND;
               res_o.ctrl.rs2_negate = 1'b1;
            end
            {F7_ALT, F3_OR}: begin
               res_o.ctrl.unit       = UNIT_ALU;
               res_o.ctrl.alu_op     = ALU_OR;
               res_o.ctrl.rs2_negate = 1'b1;
            end
            {F7_ALT, F3_XOR}: begin
               res_o.ctrl.unit   = UNIT_ALU;
               res_o.ctrl.alu_op = ALU_XNOR;
            end
            {F7_SHADD, F3_SH1ADD}, {F7_SHADD, F3_SH2ADD}, {F7_SHADD, F3_SH3ADD}: begin
               res_o.ctrl.unit      = UNIT_ALU;
               res_o.ctrl.alu_op    = ALU_ADD;
               res_o.ctrl.rs1_shift = 1'b1;
            end
            default: match = 1'b0;
         endcase
      end

      // RORI is always present
      res_o.hit = match && (SUPPORT_B || rori);
   end

endmodule

`default_nettype wire

// ==== src/decode_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl import decode_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        instr_valid_i,
   input  logic        stall_i,
   input  dec_result_t base_i,
   input  dec_result_t bitm_i,
   input  dec_result_t sys_i,
   output logic        ctrl_valid_o,
   output ctrl_t       ctrl_o
);

   localparam int CTRL_W = $bits(ctrl_t);

   // Illegal instruction word, only exc and cause set
   localparam ctrl_t ILLEGAL_CTRL = ctrl_t'({1'b1, EXC_ILLEGAL, {(CTRL_W - 5){1'b0}}});

   logic  any_hit;
   ctrl_t merged;
   ctrl_t next_ctrl;

   assign any_hit = base_i.hit | bitm_i.hit | sys_i.hit;

   // Decoders are mutually exclusive so an OR of masked bundles suffices
   assign merged = ctrl_t'(({CTRL_W{base_i.hit}} & base_i.ctrl)
                         | ({CTRL_W{bitm_i.hit}} & bitm_i.ctrl)
                         | ({CTRL_W{sys_i.hit}} & sys_i.ctrl));

   assign next_ctrl = any_hit ? merged : ILLEGAL_CTRL;

   // ID/EX register
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_valid_o <= 1'b0;
         ctrl_o       <= '0;
      end else if (!stall_i) begin
         ctrl_valid_o <= instr_valid_i;
         if (instr_valid_i) begin
            ctrl_o <= next_ctrl;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opcode_e;

   // ALU group funct3, shared by OP and OP_IMM
   localparam logic [2:0] F3_ADD  = 3'b000,
                          F3_SLL  = 3'b001,
                          F3_SLT  = 3'b010,
                          F3_SLTU = 3'b011,
                          F3_XOR  = 3'b100,
                          F3_SRL  = 3'b101,
                          F3_OR   = 3'b110,
                          F3_AND  = 3'b111;

   localparam logic [2:0] F3_LB   = 3'b000,
                          F3_LH   = 3'b001,
                          F3_LW   = 3'b010,
                          F3_LBU  = 3'b100,
                          F3_LHU  = 3'b101,
                          F3_SB   = 3'b000,
                          F3_SH   = 3'b001,
                          F3_SW   = 3'b010,
                          F3_JALR = 3'b000;

   localparam logic [2:0] F3_BEQ  = 3'b000,
                          F3_BNE  = 3'b001,
                          F3_BLT  = 3'b100,
                          F3_BGE  = 3'b101,
                          F3_BLTU = 3'b110,
                          F3_BGEU = 3'b111;

   localparam logic [2:0] F3_MIN    = 3'b100,
                          F3_MINU   = 3'b101,
                          F3_MAX    = 3'b110,
                          F3_MAXU   = 3'b111,
                          F3_SH1ADD = 3'b010,
                          F3_SH2ADD = 3'b100,
                          F3_SH3ADD = 3'b110,
                          F3_ZEXT_H = 3'b100;

   localparam logic [2:0] F3_PRIV     = 3'b000,
                          F3_CSR_RSVD = 3'b100;

   localparam logic [6:0] F7_BASE      = 7'b0000000,
                          F7_ALT       = 7'b0100000,
                          F7_MULDIV    = 7'b0000001,
                          F7_ROTATE    = 7'b0110000,
                          F7_BCLR_BEXT = 7'b0100100,
                          F7_BINV_REV8 = 7'b0110100,
                          F7_BSET_ORCB = 7'b0010100,
                          F7_MINMAX    = 7'b0000101,
                          F7_SHADD     = 7'b0010000,
                          F7_ZEXT_H    = 7'b0000100;

   localparam logic [4:0] F5_CLZ    = 5'b00000,
                          F5_CTZ    = 5'b00001,
                          F5_CPOP   = 5'b00010,
                          F5_SEXT_B = 5'b00100,
                          F5_SEXT_H = 5'b00101,
                          F5_ORC_B  = 5'b00111,
                          F5_REV8   = 5'b11000,
                          F5_ZEXT_H = 5'b00000;

   localparam logic [11:0] F12_ECALL  = 12'b0000000_00000,
                           F12_EBREAK = 12'b0000000_00001,
                           F12_WFI    = 12'b0001000_00101,
                           F12_MRET   = 12'b0011000_00010;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_view_t;

   typedef struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } i_view_t;

   // Instruction bits 31:2, rs2 also carries the B-group funct5
   typedef union packed {
      r_view_t r_view;
      i_view_t i_view;
   } instr_u;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd3,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_XNOR,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [4:0] {
      BMU_CLZ = 5'd0,
      BMU_CTZ,
      BMU_CPOP,
      BMU_ORC_B,
      BMU_REV8,
      BMU_ZEXT_H,
      BMU_SEXT_B,
      BMU_SEXT_H,
      BMU_ROL,
      BMU_ROR,
      BMU_MAX,
      BMU_BCLR,
      BMU_BEXT,
      BMU_BINV,
      BMU_BSET,
      BMU_MAXU,
      BMU_MIN,
      BMU_MINU
   } bmu_op_e;

   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_MDU = 2'd1,
      UNIT_BMU = 2'd2,
      UNIT_CSR = 2'd3
   } unit_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd3
   } wb_sel_e;

   typedef enum logic [1:0] {
      CSR_NONE  = 2'd0,
      CSR_WRITE = 2'd1,
      CSR_SET   = 2'd2,
      CSR_CLEAR = 2'd3
   } csr_op_e;

   typedef enum logic [3:0] {
      EXC_INSTR_MISALIGN = 4'd0,
      EXC_ILLEGAL        = 4'd2,
      EXC_BREAKPOINT     = 4'd3,
      EXC_LOAD_MISALIGN  = 4'd4,
      EXC_STORE_MISALIGN = 4'd6,
      EXC_ECALL_M        = 4'd11
   } exc_cause_e;

   // Control bundle handed to execute, exc and exc_cause stay on top
   typedef struct packed {
      logic       exc;
      exc_cause_e exc_cause;
      logic       is_mret;
      unit_e      unit;
      logic       csr_en;
      csr_op_e    csr_op;
      logic       csr_imm;
      alu_op_e    alu_op;
      logic       mdu_en;
      logic [2:0] mdu_op;
      bmu_op_e    bmu_op;
      logic       rs1_shift;
      logic       rs2_negate;
      logic       reg_wr_en;
      wb_sel_e    wb_sel;
      logic       op1_pc;
      logic       op2_imm;
      logic       is_load;
      logic       is_store;
   } ctrl_t;

   typedef struct packed {
      logic  hit;
      ctrl_t ctrl;
   } dec_result_t;

endpackage

`default_nettype wire

// ==== src/instr_decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode_stage import decode_pkg::*; #(
   parameter bit SUPPORT_M = 1'b1,
   parameter bit SUPPORT_B = 1'b1
) (
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   instr_valid_i,
   input  instr_u instr_i,
   input  logic   stall_i,
   output logic   ctrl_valid_o,
   output ctrl_t  ctrl_o
);

   dec_result_t base_res;
   dec_result_t bitm_res;
   dec_result_t sys_res;

   base_int_decoder #(
      .SUPPORT_M (SUPPORT_M)
   ) base_int_decoder_i (
      .instr_i (instr_i),
      .res_o   (base_res)
   );

   bitmanip_decoder #(
      .SUPPORT_B (SUPPORT_B)
   ) bitmanip_decoder_i (
      .instr_i (instr_i),
      .res_o   (bitm_res)
   );

   system_decoder system_decoder_i (
      .instr_i (instr_i),
      .res_o   (sys_res)
   );

   decode_ctrl decode_ctrl_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_valid_i (instr_valid_i),
      .stall_i       (stall_i),
      .base_i        (base_res),
      .bitm_i        (bitm_res),
      .sys_i         (sys_res),
      .ctrl_valid_o  (ctrl_valid_o),
      .ctrl_o        (ctrl_o)
   );

endmodule

`default_nettype wire

// ==== src/system_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module system_decoder import decode_pkg::*; (
   input  instr_u      instr_i,
   output dec_result_t res_o
);

   logic [2:0] funct3;
   logic       no_regs;

   assign funct3  = instr_i.i_view.funct3;
   assign no_regs = (instr_i.i_view.rd == 5'd0) && (instr_i.i_view.rs1 == 5'd0);

   always_comb begin
      res_o = '0;
      if (instr_i.i_view.opcode == OPC_SYSTEM) begin
         if (funct3 == F3_PRIV) begin
            if (no_regs) begin
               case (instr_i.i_view.funct12)
                  F12_ECALL: begin
                     res_o.hit            = 1'b1;
                     res_o.ctrl.exc       = 1'b1;
                     res_o.ctrl.exc_cause = EXC_ECALL_M;
                  end
                  F12_EBREAK: begin
                     res_o.hit            = 1'b1;
                     res_o.ctrl.exc       = 1'b1;
                     res_o.ctrl.exc_cause = EXC_BREAKPOINT;
                  end
                  F12_MRET: begin
                     res_o.hit          = 1'b1;
                     res_o.ctrl.is_mret = 1'b1;
                  end
                  // WFI retires as a no-op
                  F12_WFI: res_o.hit = 1'b1;
                  default: ;
               endcase
            end
         end else if (funct3 != F3_CSR_RSVD) begin
            // funct3[1:0] is the CSR operation, funct3[2] picks the uimm form
            res_o.hit            = 1'b1;
            res_o.ctrl.unit      = UNIT_CSR;
            res_o.ctrl.csr_en    = 1'b1;
            res_o.ctrl.csr_op    = csr_op_e'(funct3[1:0]);
            res_o.ctrl.csr_imm   = funct3[2];
            res_o.ctrl.reg_wr_en = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verif/tb_instr_decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_instr_decode_stage import decode_pkg::*; #(
   parameter bit TB_SUPPORT_M = 1'b1,
   parameter bit TB_SUPPORT_B = 1'b1
);

   localparam int CLK_PERIOD = 10;
   localparam int N_RANDOM   = 200;
   // Base, M, B, system, illegal and stall vectors
   localparam int N_DIRECTED = 11 + 8 + 79 + 12 + 2 + 5;
   localparam logic [31:0] SEED = 32'hb7c3_2124;

   // Major opcodes in bits 6:2
   localparam logic [4:0] O_LOAD   = 5'b00000,
                          O_OP_IMM = 5'b00100,
                          O_AUIPC  = 5'b00101,
                          O_STORE  = 5'b01000,
                          O_AMO    = 5'b01011,
                          O_OP     = 5'b01100,
                          O_LUI    = 5'b01101,
                          O_BRANCH = 5'b11000,
                          O_JALR   = 5'b11001,
                          O_JAL    = 5'b11011,
                          O_SYSTEM = 5'b11100;

   localparam logic [6:0] OP_F7 [8] = '{7'h30, 7'h24, 7'h34, 7'h14,
                                        7'h05, 7'h20, 7'h10, 7'h04};

   logic        clk;
   logic        rst_n;
   logic        instr_valid_i;
   instr_u      instr_i;
   logic        stall_i;
   logic        ctrl_valid_o;
   ctrl_t       ctrl_o;

   ctrl_t       exp_now;
   ctrl_t       exp_q;
   ctrl_t       prev_ctrl;
   logic        prev_valid;
   string       test_name;
   string       name_q;
   logic        acc_q   = 1'b0;
   logic        stall_q = 1'b0;
   logic        idle_q  = 1'b0;
   logic        seen_q  = 1'b0;
   logic [31:0] lfsr;
   int          errors  = 0;

   tb_clk_gen clk_gen_i (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   instr_decode_stage #(
      .SUPPORT_M (TB_SUPPORT_M),
      .SUPPORT_B (TB_SUPPORT_B)
   ) instr_decode_stage_i (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .stall_i       (stall_i),
      .ctrl_valid_o  (ctrl_valid_o),
      .ctrl_o        (ctrl_o)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [2:0] f3, input logic [4:0] opc);
      return {f7, rs2, 5'd6, f3, 5'd7, opc, 2'b11};
   endfunction

   function automatic logic [31:0] sys_word(input logic [11:0] f12, input logic [4:0] rd);
      return {f12, 5'd0, 3'd0, rd, O_SYSTEM, 2'b11};
   endfunction

   function automatic alu_op_e alu_for(input logic [2:0] f3);
      case (f3)
         3'd0:    return ALU_ADD;
         3'd1:    return ALU_SLL;
         3'd2:    return ALU_SLT;
         3'd3:    return ALU_SLTU;
         3'd4:    return ALU_XOR;
         3'd5:    return ALU_SRL;
         3'd6:    return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   // Expected control word for a full 32-bit instruction
   function automatic ctrl_t ref_decode(input logic [31:0] w);
      logic [6:0] f7;
      logic [4:0] rs2;
      logic [2:0] f3;
      logic       hit;
      logic       bext;
      logic       mext;
      ctrl_t      c;
      f7   = w[31:25];
      rs2  = w[24:20];
      f3   = w[14:12];
      c    = '0;
      hit  = 1'b1;
      bext = 1'b0;
      mext = 1'b0;
      case (w[6:2])
         O_LOAD: begin
            hit         = (f3 != 3'd3) && (f3 < 3'd6);
            c.exc_cause = EXC_LOAD_MISALIGN;
            c.reg_wr_en = 1'b1;
            c.wb_sel    = WB_MEM;
            c.op2_imm   = 1'b1;
            c.is_load   = 1'b1;
         end
         O_STORE: begin
            hit         = (f3 < 3'd3);
            c.exc_cause = EXC_STORE_MISALIGN;
            c.op2_imm   = 1'b1;
            c.is_store  = 1'b1;
         end
         O_BRANCH: begin
            hit         = (f3[2:1] != 2'b01);
            c.exc_cause = EXC_INSTR_MISALIGN;
            c.op1_pc    = 1'b1;
            c.op2_imm   = 1'b1;
         end
         O_JAL, O_JALR: begin
            hit         = (w[6:2] == O_JAL) || (f3 == 3'd0);
            c.reg_wr_en = 1'b1;
            c.wb_sel    = WB_PC4;
            c.op1_pc    = (w[6:2] == O_JAL);
            c.op2_imm   = 1'b1;
         end
         O_LUI, O_AUIPC: begin
            c.alu_op    = (w[6:2] == O_LUI) ? ALU_PASS_B : ALU_ADD;
            c.reg_wr_en = 1'b1;
            c.op1_pc    = (w[6:2] == O_AUIPC);
            c.op2_imm   = 1'b1;
         end
         O_OP_IMM: begin
            c.reg_wr_en = 1'b1;
            c.op2_imm   = 1'b1;
            if (f3 == 3'd1 || f3 == 3'd5) begin
               c.unit = UNIT_BMU;
               bext   = 1'b1;
               case ({f7, f3[2]})
                  {7'h00, 1'b0}: {c.unit, bext, c.alu_op} = {UNIT_ALU, 1'b0, ALU_SLL};
                  {7'h00, 1'b1}: {c.unit, bext, c.alu_op} = {UNIT_ALU, 1'b0, ALU_SRL};
                  {7'h20, 1'b1}: {c.unit, bext, c.alu_op} = {UNIT_ALU, 1'b0, ALU_SRA};
                  {7'h30, 1'b1}: {bext, c.bmu_op} = {1'b0, BMU_ROR};
                  {7'h30, 1'b0}: begin
                     case (rs2)
                        5'd0:    c.bmu_op = BMU_CLZ;
                        5'd1:    c.bmu_op = BMU_CTZ;
                        5'd2:    c.bmu_op = BMU_CPOP;
                        5'd4:    c.bmu_op = BMU_SEXT_B;
                        5'd5:    c.bmu_op = BMU_SEXT_H;
                        default: hit = 1'b0;
                     endcase
                  end
                  {7'h24, 1'b0}: c.bmu_op = BMU_BCLR;
                  {7'h24, 1'b1}: c.bmu_op = BMU_BEXT;
                  {7'h34, 1'b0}: c.bmu_op = BMU_BINV;
                  {7'h34, 1'b1}: {hit, c.bmu_op} = {rs2 == 5'h18, BMU_REV8};
                  {7'h14, 1'b0}: c.bmu_op = BMU_BSET;
                  {7'h14, 1'b1}: {hit, c.bmu_op} = {rs2 == 5'h07, BMU_ORC_B};
                  default:       hit = 1'b0;
               endcase
            end else begin
               c.alu_op = alu_for(f3);
            end
         end
         O_OP: begin
            c.reg_wr_en = 1'b1;
            case (f7)
               7'h00: c.alu_op = alu_for(f3);
               7'h01: begin
                  mext     = 1'b1;
                  c.unit   = UNIT_MDU;
                  c.mdu_en = 1'b1;
                  c.mdu_op = f3;
               end
               7'h20: begin
                  bext = (f3 >= 3'd4) && (f3 != 3'd5);
                  case (f3)
                     3'd0:    {c.alu_op, c.rs2_negate} = {ALU_SUB, 1'b1};
                     3'd5:    c.alu_op = ALU_SRA;
                     3'd4:    c.alu_op = ALU_XNOR;
                     3'd6:    {c.alu_op, c.rs2_negate} = {ALU_OR, 1'b1};
                     3'd7:    {c.alu_op, c.rs2_negate} = {ALU_AND, 1'b1};
                     default: hit = 1'b0;
                  endcase
               end
               7'h10: begin
                  bext        = 1'b1;
                  hit         = (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd6);
                  c.rs1_shift = 1'b1;
               end
               default: begin
                  bext   = 1'b1;
                  c.unit = UNIT_BMU;
                  case ({f7, f3})
                     {7'h30, 3'd1}: c.bmu_op = BMU_ROL;
                     {7'h30, 3'd5}: c.bmu_op = BMU_ROR;
                     {7'h24, 3'd1}: c.bmu_op = BMU_BCLR;
                     {7'h24, 3'd5}: c.bmu_op = BMU_BEXT;
                     {7'h34, 3'd1}: c.bmu_op = BMU_BINV;
                     {7'h14, 3'd1}: c.bmu_op = BMU_BSET;
                     {7'h05, 3'd4}: c.bmu_op = BMU_MIN;
                     {7'h05, 3'd5}: c.bmu_op = BMU_MINU;
                     {7'h05, 3'd6}: c.bmu_op = BMU_MAX;
                     {7'h05, 3'd7}: c.bmu_op = BMU_MAXU;
                     {7'h04, 3'd4}: {hit, c.bmu_op} = {rs2 == 5'd0, BMU_ZEXT_H};
                     default:       hit = 1'b0;
                  endcase
               end
            endcase
         end
         O_SYSTEM: begin
            if (f3 == 3'd0) begin
               hit = (w[11:7] == 5'd0) && (w[19:15] == 5'd0);
               case (w[31:20])
                  12'h000: {c.exc, c.exc_cause} = {1'b1, EXC_ECALL_M};
                  12'h001: {c.exc, c.exc_cause} = {1'b1, EXC_BREAKPOINT};
                  12'h302: c.is_mret = 1'b1;
                  12'h105: ;
                  default: hit = 1'b0;
               endcase
            end else begin
               hit         = (f3 != 3'd4);
               c.unit      = UNIT_CSR;
               c.csr_en    = 1'b1;
               c.csr_imm   = (f3 >= 3'd5);
               c.reg_wr_en = 1'b1;
               case (f3[1:0])
                  2'd1:    c.csr_op = CSR_WRITE;
                  2'd2:    c.csr_op = CSR_SET;
                  default: c.csr_op = CSR_CLEAR;
               endcase
            end
         end
         default: hit = 1'b0;
      endcase
      if ((bext && !TB_SUPPORT_B) || (mext && !TB_SUPPORT_M)) begin
         hit = 1'b0;
      end
      if (!hit) begin
         c           = '0;
         c.exc       = 1'b1;
         c.exc_cause = EXC_ILLEGAL;
      end
      return c;
   endfunction

   task automatic set_word(input string name, input logic [31:0] w);
      test_name = name;
      instr_i   = w[31:2];
      exp_now   = ref_decode(w);
   endtask

   task automatic send(input string name, input logic [31:0] w);
      @(negedge clk);
      set_word(name, w);
      instr_valid_i = 1'b1;
   endtask

   task automatic next_rand(output logic [31:0] w);
      w = '0;
      for (int b = 0; b < 32; b++) begin
         lfsr = lfsr_step(lfsr);
         w    = {w[30:0], lfsr[0]};
      end
   endtask

   // What the register did at the last rising edge
   always @(posedge clk) begin
      if (!rst_n) begin
         acc_q   <= 1'b0;
         stall_q <= 1'b0;
         idle_q  <= 1'b0;
         seen_q  <= 1'b0;
      end else begin
         acc_q   <= instr_valid_i && !stall_i;
         stall_q <= stall_i;
         idle_q  <= !instr_valid_i && !stall_i;
         seen_q  <= seen_q || (instr_valid_i && !stall_i);
         if (instr_valid_i && !stall_i) begin
            exp_q  <= exp_now;
            name_q <= test_name;
         end
      end
      prev_ctrl  <= ctrl_o;
      prev_valid <= ctrl_valid_o;
   end

   reset_check: assert property (@(negedge clk) disable iff (!rst_n)
      !seen_q |-> (!ctrl_valid_o && ctrl_o == '0))
   else begin
      errors++;
      $display("Mismatch reset: expected %h, actual %h", 1'b0, {ctrl_valid_o, ctrl_o});
   end

   decode_check: assert property (@(negedge clk) disable iff (!rst_n)
      acc_q |-> (ctrl_valid_o && ctrl_o == exp_q))
   else begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name_q, {1'b1, exp_q},
               {ctrl_valid_o, ctrl_o});
   end

   stall_check: assert property (@(negedge clk) disable iff (!rst_n)
      stall_q |-> (ctrl_valid_o == prev_valid && ctrl_o == prev_ctrl))
   else begin
      errors++;
      $display("Mismatch stall_hold: expected %h, actual %h", {prev_valid, prev_ctrl},
               {ctrl_valid_o, ctrl_o});
   end

   idle_check: assert property (@(negedge clk) disable iff (!rst_n)
      idle_q |-> !ctrl_valid_o)
   else begin
      errors++;
      $display("Mismatch idle: expected %b, actual %b", 1'b0, ctrl_valid_o);
   end

   initial begin
      #((N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD);
      $display("Timeout: the run did not finish in the expected time");
      $display("test failed");
      $finish;
   end

   initial begin
      logic [31:0] w;
      lfsr          = SEED;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      stall_i       = 1'b0;
      exp_now       = '0;
      test_name     = "idle";
      @(posedge rst_n);
      repeat (2) @(negedge clk);

      send("addi", enc(7'h00, 5'd5, 3'd0, O_OP_IMM));
      send("sub", enc(7'h20, 5'd3, 3'd0, O_OP));
      send("sltu", enc(7'h00, 5'd3, 3'd3, O_OP));
      send("lw", enc(7'h00, 5'd4, 3'd2, O_LOAD));
      send("sw", enc(7'h00, 5'd4, 3'd2, O_STORE));
      send("beq", enc(7'h00, 5'd4, 3'd0, O_BRANCH));
      send("jal", enc(7'h12, 5'd4, 3'd5, O_JAL));
      send("jalr", enc(7'h00, 5'd8, 3'd0, O_JALR));
      send("lui", enc(7'h7f, 5'h1f, 3'd2, O_LUI));
      send("auipc", enc(7'h01, 5'd2, 3'd3, O_AUIPC));
      send("srai", enc(7'h20, 5'd3, 3'd5, O_OP_IMM));
      for (int i = 0; i < 8; i++) begin
         send($sformatf("muldiv_f3_%0d", i), enc(7'h01, 5'd3, 3'(i), O_OP));
      end

      // Unary group over funct5 0 to 7 with the gaps
      for (int i = 0; i < 8; i++) begin
         send($sformatf("unary_f5_%0d", i), enc(7'h30, 5'(i), 3'd1, O_OP_IMM));
      end
      send("rori", enc(7'h30, 5'd3, 3'd5, O_OP_IMM));
      send("bclri", enc(7'h24, 5'd3, 3'd1, O_OP_IMM));
      send("bexti", enc(7'h24, 5'd3, 3'd5, O_OP_IMM));
      send("binvi", enc(7'h34, 5'd3, 3'd1, O_OP_IMM));
      send("rev8", enc(7'h34, 5'h18, 3'd5, O_OP_IMM));
      send("bseti", enc(7'h14, 5'd3, 3'd1, O_OP_IMM));
      send("orc_b", enc(7'h14, 5'h07, 3'd5, O_OP_IMM));
      for (int i = 0; i < 8; i++) begin
         for (int j = 0; j < 8; j++) begin
            send($sformatf("op_f7_%h_f3_%0d", OP_F7[i], j), enc(OP_F7[i], 5'd0, 3'(j), O_OP));
         end
      end

      for (int i = 1; i < 8; i++) begin
         send($sformatf("csr_f3_%0d", i), enc(7'h18, 5'd0, 3'(i), O_SYSTEM));
      end
      send("ecall", sys_word(12'h000, 5'd0));
      send("ebreak", sys_word(12'h001, 5'd0));
      send("mret", sys_word(12'h302, 5'd0));
      send("wfi", sys_word(12'h105, 5'd0));
      send("ecall_rd", sys_word(12'h000, 5'd1));

      send("amo", enc(7'h00, 5'd3, 3'd2, O_AMO));
      send("op_bad_f7", enc(7'h7f, 5'd3, 3'd0, O_OP));
      for (int i = 0; i < N_RANDOM; i++) begin
         next_rand(w);
         send($sformatf("random_%0d", i), w);
      end

      // Word and valid change under stall and only the last word goes through
      send("stall_addi", enc(7'h00, 5'd9, 3'd0, O_OP_IMM));
      @(negedge clk);
      stall_i = 1'b1;
      for (int i = 0; i < 4; i++) begin
         next_rand(w);
         set_word($sformatf("stall_word_%0d", i), w);
         instr_valid_i = i[0];
         @(negedge clk);
      end
      stall_i = 1'b0;
      @(negedge clk);
      instr_valid_i = 1'b0;
      repeat (2) @(posedge clk);

      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
